// File: bench/core_tb.sv
module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_COUNT  = 5;
    localparam int IDLE_SLOTS  = 10;
    localparam int ALU_SLOTS   = 200;
    localparam int HILO_SLOTS  = 150;
    localparam int MIXED_SLOTS = 80;
    // the hi/lo test can issue two instructions per slot
    localparam int CYCLE_LIMIT = 2 + IDLE_SLOTS + 1 + ALU_SLOTS + 2 * HILO_SLOTS
                               + MIXED_SLOTS + 20 * TEST_COUNT;

    typedef struct packed {
        mips_isa_pkg::reg_idx_t num;
        mips_isa_pkg::word_t    data;
    } exp_write_t;

    logic                   clk;
    logic                   reset;
    logic                   inst_valid;
    mips_isa_pkg::word_t    inst;
    logic                   trace_valid;
    mips_isa_pkg::reg_idx_t trace_wnum;
    mips_isa_pkg::word_t    trace_wdata;

    integer              seed = 32'h4299_8ceb;
    mips_isa_pkg::word_t model_regs [32];
    mips_isa_pkg::word_t model_hi;
    mips_isa_pkg::word_t model_lo;
    exp_write_t          exp_q [$];
    exp_write_t          popped;
    int                  cycle_count = 0;
    int                  errors = 0;
    int                  checks = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;

    core_top core_top_i (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .trace_valid(trace_valid),
        .trace_wnum (trace_wnum),
        .trace_wdata(trace_wdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////
    // encoders and random picks
    function automatic mips_isa_pkg::word_t encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                                     input logic [4:0] rd, input logic [4:0] sa,
                                                     input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic mips_isa_pkg::word_t encode_i(input logic [5:0] op, input logic [4:0] rs,
                                                     input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // small register window so back-to-back instructions depend on each other
    function automatic mips_isa_pkg::reg_idx_t pick_reg();
        mips_isa_pkg::reg_idx_t r;
        r = $random(seed);
        return r & 5'd7;
    endfunction

    function automatic mips_isa_pkg::word_t random_alu_inst();
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        kind = {$random(seed)} % 17;
        rs = pick_reg();
        rt = pick_reg();
        rd = pick_reg();
        sa = $random(seed);
        imm = $random(seed);
        case (kind)
            0:  return encode_r(rs, rt, rd, 5'd0, mips_isa_pkg::F_ADDU);
            1:  return encode_r(rs, rt, rd, 5'd0, mips_isa_pkg::F_SUBU);
            2:  return encode_r(rs, rt, rd, 5'd0, mips_isa_pkg::F_AND);
            3:  return encode_r(rs, rt, rd, 5'd0, mips_isa_pkg::F_OR);
            4:  return encode_r(rs, rt, rd, 5'd0, mips_isa_pkg::F_XOR);
            5:  return encode_r(rs, rt, rd, 5'd0, mips_isa_pkg::F_NOR);
            6:  return encode_r(rs, rt, rd, 5'd0, mips_isa_pkg::F_SLT);
            7:  return encode_r(rs, rt, rd, 5'd0, mips_isa_pkg::F_SLTU);
            8:  return encode_r(5'd0, rt, rd, sa, mips_isa_pkg::F_SLL);
            9:  return encode_r(5'd0, rt, rd, sa, mips_isa_pkg::F_SRL);
            10: return encode_r(5'd0, rt, rd, sa, mips_isa_pkg::F_SRA);
            11: return encode_i(mips_isa_pkg::OP_ADDIU, rs, rt, imm);
            12: return encode_i(mips_isa_pkg::OP_SLTI, rs, rt, imm);
            13: return encode_i(mips_isa_pkg::OP_ANDI, rs, rt, imm);
            14: return encode_i(mips_isa_pkg::OP_ORI, rs, rt, imm);
            15: return encode_i(mips_isa_pkg::OP_XORI, rs, rt, imm);
            default: return encode_i(mips_isa_pkg::OP_LUI, 5'd0, rt, imm);
        endcase
    endfunction

    ////////////////////
    // reference model, applied in issue order
    function automatic void apply_to_model(input mips_isa_pkg::word_t w);
        logic [5:0]          op;
        logic [5:0]          fn;
        logic [4:0]          rs;
        logic [4:0]          rt;
        logic [4:0]          rd;
        logic [4:0]          dest;
        logic [4:0]          sa;
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        mips_isa_pkg::word_t simm;
        mips_isa_pkg::word_t zimm;
        mips_isa_pkg::word_t res;
        logic [63:0]         prod;
        logic                wr;
        exp_write_t          item;
        op = w[31:26];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        sa = w[10:6];
        fn = w[5:0];
        a = model_regs[rs];
        b = model_regs[rt];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'h0000, w[15:0]};
        wr = 1'b1;
        dest = rt;
        res = '0;
        case (op)
            mips_isa_pkg::OP_SPECIAL: begin
                dest = rd;
                case (fn)
                    mips_isa_pkg::F_SLL:  res = b << sa;
                    mips_isa_pkg::F_SRL:  res = b >> sa;
                    mips_isa_pkg::F_SRA:  res = $signed(b) >>> sa;
                    mips_isa_pkg::F_MFHI: res = model_hi;
                    mips_isa_pkg::F_MFLO: res = model_lo;
                    mips_isa_pkg::F_MTHI: begin
                        model_hi = a;
                        wr = 1'b0;
                    end
                    mips_isa_pkg::F_MTLO: begin
                        model_lo = a;
                        wr = 1'b0;
                    end
                    mips_isa_pkg::F_MULT: begin
                        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                        model_hi = prod[63:32];
                        model_lo = prod[31:0];
                        wr = 1'b0;
                    end
                    mips_isa_pkg::F_MULTU: begin
                        prod = {32'h0, a} * {32'h0, b};
                        model_hi = prod[63:32];
                        model_lo = prod[31:0];
                        wr = 1'b0;
                    end
                    mips_isa_pkg::F_ADDU: res = a + b;
                    mips_isa_pkg::F_SUBU: res = a - b;
                    mips_isa_pkg::F_AND:  res = a & b;
                    mips_isa_pkg::F_OR:   res = a | b;
                    mips_isa_pkg::F_XOR:  res = a ^ b;
                    mips_isa_pkg::F_NOR:  res = ~(a | b);
                    mips_isa_pkg::F_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    mips_isa_pkg::F_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_ADDIU: res = a + simm;
            mips_isa_pkg::OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            mips_isa_pkg::OP_ANDI:  res = a & zimm;
            mips_isa_pkg::OP_ORI:   res = a | zimm;
            mips_isa_pkg::OP_XORI:  res = a ^ zimm;
            mips_isa_pkg::OP_LUI:   res = {w[15:0], 16'h0000};
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin
            model_regs[dest] = res;
            item.num = dest;
            item.data = res;
            exp_q.push_back(item);
        end
    endfunction

    ////////////////////
    // stimulus
    task automatic issue_inst(input mips_isa_pkg::word_t w);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst <= w;
        apply_to_model(w);
    endtask

    // junk on inst while valid is low must be ignored
    task automatic idle_cycle();
        @(posedge clk);
        inst_valid <= 1'b0;
        inst <= $random(seed);
    endtask

    task automatic end_test(input string name, input int err_before);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 10) begin
            idle_cycle();
            n++;
        end
        // a few more edges so a stray trace still shows up
        repeat (4) idle_cycle();
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected register writes never appeared", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // trace is compared at the falling edge where it is stable
    always @(negedge clk) begin
        if (!reset && trace_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("unexpected trace at %0t: r%0d written with %h but no write was due",
                         $time, trace_wnum, trace_wdata);
                errors++;
            end else begin
                popped = exp_q.pop_front();
                checks++;
                if (trace_wnum !== popped.num || trace_wdata !== popped.data) begin
                    $display("FAIL %0t: trace expected r%0d=%h, seen r%0d=%h", $time,
                             popped.num, popped.data, trace_wnum, trace_wdata);
                    errors++;
                end
            end
        end
    end

    initial begin
        int          err_before;
        int          lat;
        int          kind;
        logic        seen;
        logic [4:0]  rd;
        logic [15:0] imm;
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        model_hi = '0;
        model_lo = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // idle after reset
        err_before = errors;
        repeat (IDLE_SLOTS) begin
            idle_cycle();
            @(negedge clk);
            checks++;
            if (trace_valid !== 1'b0) begin
                $display("FAIL %0t: trace_valid is %b while idle", $time, trace_valid);
                errors++;
            end
        end
        end_test("idle_after_reset", err_before);

        // single instruction, latency measured in edges after the sampling edge
        err_before = errors;
        imm = $random(seed);
        issue_inst(encode_i(mips_isa_pkg::OP_ADDIU, 5'd3, 5'd5, imm));
        idle_cycle();
        lat = 0;
        seen = 1'b0;
        while (lat < 10 && !seen) begin
            idle_cycle();
            lat++;
            @(negedge clk);
            if (trace_valid === 1'b1) begin
                seen = 1'b1;
            end
        end
        checks++;
        if (!seen) begin
            $display("single addiu produced no trace within 10 cycles");
            errors++;
        end else if (lat != 3) begin
            $display("FAIL %0t: trace latency expected 3 edges, seen %0d", $time, lat);
            errors++;
        end
        end_test("single_immediate", err_before);

        err_before = errors;
        repeat (ALU_SLOTS) issue_inst(random_alu_inst());
        end_test("alu_stream", err_before);

        ////////////////////
        // hi/lo traffic, mult pairs put mfhi or mflo right behind
        err_before = errors;
        repeat (HILO_SLOTS) begin
            kind = {$random(seed)} % 8;
            rd = pick_reg();
            case (kind)
                0: begin
                    issue_inst(encode_r(pick_reg(), pick_reg(), 5'd0, 5'd0, mips_isa_pkg::F_MULT));
                    issue_inst(encode_r(5'd0, 5'd0, rd, 5'd0, mips_isa_pkg::F_MFHI));
                end
                1: begin
                    issue_inst(encode_r(pick_reg(), pick_reg(), 5'd0, 5'd0, mips_isa_pkg::F_MULTU));
                    issue_inst(encode_r(5'd0, 5'd0, rd, 5'd0, mips_isa_pkg::F_MFLO));
                end
                2: issue_inst(encode_r(pick_reg(), 5'd0, 5'd0, 5'd0, mips_isa_pkg::F_MTHI));
                3: issue_inst(encode_r(pick_reg(), 5'd0, 5'd0, 5'd0, mips_isa_pkg::F_MTLO));
                4: issue_inst(encode_r(5'd0, 5'd0, rd, 5'd0, mips_isa_pkg::F_MFHI));
                5: issue_inst(encode_r(5'd0, 5'd0, rd, 5'd0, mips_isa_pkg::F_MFLO));
                default: issue_inst(random_alu_inst());
            endcase
        end
        end_test("hilo_mix", err_before);

        // r0 writes, unknown encodings, gaps and reads of r0
        err_before = errors;
        repeat (MIXED_SLOTS) begin
            kind = {$random(seed)} % 6;
            imm = $random(seed);
            rd = pick_reg();
            if (rd == 5'd0) begin
                rd = 5'd1;
            end
            case (kind)
                0: idle_cycle();
                1: issue_inst(encode_i(mips_isa_pkg::OP_ADDIU, pick_reg(), 5'd0, imm));
                2: issue_inst(encode_i(6'h23, pick_reg(), pick_reg(), imm));
                3: issue_inst(encode_r(pick_reg(), 5'd0, 5'd0, 5'd0, 6'h08));
                4: issue_inst(encode_i(6'h08, pick_reg(), pick_reg(), imm));
                default: issue_inst(encode_r(5'd0, 5'd0, rd, 5'd0, mips_isa_pkg::F_ADDU));
            endcase
        end
        end_test("no_trace_cases", err_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: list.f
src/mips_isa_pkg.sv
src/pipe_pkg.sv
src/decode_control.sv
src/reg_file.sv
src/operand_bypass.sv
src/alu.sv
src/hilo_reg.sv
src/retire_stage.sv
src/core_top.sv
bench/core_tb.sv

// File: src/alu.sv
module alu (
    input  pipe_pkg::alu_op_e   op,
    input  mips_isa_pkg::word_t a,
    input  mips_isa_pkg::word_t b,
    output mips_isa_pkg::word_t result,
    output mips_isa_pkg::word_t prod_hi,
    output mips_isa_pkg::word_t prod_lo
);

    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] product;
    logic        [4:0]  sh;

    assign sh = b[4:0];

    // one 33-bit signed multiplier covers mult and multu
    assign mul_a = {op == pipe_pkg::ALU_MULT && a[31], a};
    assign mul_b = {op == pipe_pkg::ALU_MULT && b[31], b};
    assign product = mul_a * mul_b;
    assign prod_hi = product[63:32];
    assign prod_lo = product[31:0];

    always_comb begin
        case (op)
            pipe_pkg::ALU_ADD:   result = a + b;
            pipe_pkg::ALU_SUB:   result = a - b;
            pipe_pkg::ALU_AND:   result = a & b;
            pipe_pkg::ALU_OR:    result = a | b;
            pipe_pkg::ALU_XOR:   result = a ^ b;
            pipe_pkg::ALU_NOR:   result = ~(a | b);
            pipe_pkg::ALU_SLT:   result = {31'd0, $signed(a) < $signed(b)};
            pipe_pkg::ALU_SLTU:  result = {31'd0, a < b};
            pipe_pkg::ALU_SLL:   result = a << sh;
            pipe_pkg::ALU_SRL:   result = a >> sh;
            pipe_pkg::ALU_SRA:   result = $signed(a) >>> sh;
            pipe_pkg::ALU_PASSB: result = b;
            // products leave through prod_hi and prod_lo
            pipe_pkg::ALU_MULT, pipe_pkg::ALU_MULTU: result = '0;
            default: result = '0;
        endcase
    end

endmodule

// File: src/core_top.sv
module core_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  mips_isa_pkg::word_t    inst,
    output logic                   trace_valid,
    output mips_isa_pkg::reg_idx_t trace_wnum,
    output mips_isa_pkg::word_t    trace_wdata
);

    mips_isa_pkg::reg_idx_t rs_addr;
    mips_isa_pkg::reg_idx_t rt_addr;
    mips_isa_pkg::word_t    rs_data;
    mips_isa_pkg::word_t    rt_data;
    pipe_pkg::ex_stage_t    ex_stage;
    pipe_pkg::retire_t      retire;
    mips_isa_pkg::word_t    rs_val;
    mips_isa_pkg::word_t    rt_val;
    mips_isa_pkg::word_t    alu_a;
    mips_isa_pkg::word_t    alu_b;
    mips_isa_pkg::word_t    alu_result;
    mips_isa_pkg::word_t    prod_hi;
    mips_isa_pkg::word_t    prod_lo;
    mips_isa_pkg::word_t    hi;
    mips_isa_pkg::word_t    lo;

    ////////////////////
    // decode
    decode_control decode_control_i (
        .clk       (clk),
        .reset     (reset),
        .inst_valid(inst_valid),
        .inst      (inst),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .ex_stage  (ex_stage)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .reset  (reset),
        .rs_addr(rs_addr),
        .rt_addr(rt_addr),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .retire (retire)
    );

    ////////////////////
    // execute
    operand_bypass rs_bypass_i (
        .src_addr  (ex_stage.rs),
        .stale_data(ex_stage.rs_data),
        .retire    (retire),
        .data      (rs_val)
    );

    operand_bypass rt_bypass_i (
        .src_addr  (ex_stage.rt),
        .stale_data(ex_stage.rt_data),
        .retire    (retire),
        .data      (rt_val)
    );

    // shifts move rt by shamt, everything else works on rs
    always_comb begin
        alu_a = ex_stage.ctl.shift_by_shamt ? rt_val : rs_val;
        if (ex_stage.ctl.shift_by_shamt) begin
            alu_b = {27'd0, ex_stage.shamt};
        end else begin
            case (ex_stage.ctl.src2_sel)
                pipe_pkg::SRC2_SIMM: alu_b = {{16{ex_stage.imm[15]}}, ex_stage.imm};
                pipe_pkg::SRC2_ZIMM: alu_b = {16'd0, ex_stage.imm};
                pipe_pkg::SRC2_UIMM: alu_b = {ex_stage.imm, 16'd0};
                default:             alu_b = rt_val;
            endcase
        end
    end

    alu alu_i (
        .op     (ex_stage.ctl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .prod_hi(prod_hi),
        .prod_lo(prod_lo)
    );

    hilo_reg hilo_reg_i (
        .clk   (clk),
        .reset (reset),
        .retire(retire),
        .hi    (hi),
        .lo    (lo)
    );

    ////////////////////
    // retire
    retire_stage retire_stage_i (
        .clk        (clk),
        .reset      (reset),
        .ex_stage   (ex_stage),
        .rs_val     (rs_val),
        .alu_result (alu_result),
        .prod_hi    (prod_hi),
        .prod_lo    (prod_lo),
        .hi         (hi),
        .lo         (lo),
        .retire     (retire),
        .trace_valid(trace_valid),
        .trace_wnum (trace_wnum),
        .trace_wdata(trace_wdata)
    );

endmodule

// File: src/decode_control.sv
module decode_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  mips_isa_pkg::word_t    inst,
    input  mips_isa_pkg::word_t    rs_data,
    input  mips_isa_pkg::word_t    rt_data,
    output mips_isa_pkg::reg_idx_t rs_addr,
    output mips_isa_pkg::reg_idx_t rt_addr,
    output pipe_pkg::ex_stage_t    ex_stage
);

    logic                   dec_valid;
    mips_isa_pkg::word_t    dec_inst;
    mips_isa_pkg::opcode_t  opcode;
    mips_isa_pkg::funct_t   funct;
    mips_isa_pkg::reg_idx_t rd;
    pipe_pkg::ctl_t         ctl;
    logic                   known;
    pipe_pkg::ex_stage_t    ex_next;

    // decode slot
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
        end
        dec_inst <= inst;
    end

    assign opcode  = dec_inst[mips_isa_pkg::OPCODE_LSB +: 6];
    assign funct   = dec_inst[mips_isa_pkg::FUNCT_LSB +: 6];
    assign rs_addr = dec_inst[mips_isa_pkg::RS_LSB +: 5];
    assign rt_addr = dec_inst[mips_isa_pkg::RT_LSB +: 5];
    assign rd      = dec_inst[mips_isa_pkg::RD_LSB +: 5];

    ////////////////////
    // control decode
    always_comb begin
        ctl = '0;
        ctl.alu_op = pipe_pkg::ALU_ADD;
        ctl.src2_sel = pipe_pkg::SRC2_REG;
        ctl.result_sel = pipe_pkg::RES_ALU;
        ctl.rf_wen = 1'b1;
        ctl.waddr = rt_addr;
        known = 1'b1;
        case (opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                ctl.waddr = rd;
                case (funct)
                    mips_isa_pkg::F_SLL: begin
                        ctl.alu_op = pipe_pkg::ALU_SLL;
                        ctl.shift_by_shamt = 1'b1;
                    end
                    mips_isa_pkg::F_SRL: begin
                        ctl.alu_op = pipe_pkg::ALU_SRL;
                        ctl.shift_by_shamt = 1'b1;
                    end
                    mips_isa_pkg::F_SRA: begin
                        ctl.alu_op = pipe_pkg::ALU_SRA;
                        ctl.shift_by_shamt = 1'b1;
                    end
                    mips_isa_pkg::F_MFHI: ctl.result_sel = pipe_pkg::RES_HI;
                    mips_isa_pkg::F_MFLO: ctl.result_sel = pipe_pkg::RES_LO;
                    mips_isa_pkg::F_MTHI: begin
                        ctl.rf_wen = 1'b0;
                        ctl.hi_wen = 1'b1;
                        ctl.hilo_from_rs = 1'b1;
                    end
                    mips_isa_pkg::F_MTLO: begin
                        ctl.rf_wen = 1'b0;
                        ctl.lo_wen = 1'b1;
                        ctl.hilo_from_rs = 1'b1;
                    end
                    mips_isa_pkg::F_MULT, mips_isa_pkg::F_MULTU: begin
                        ctl.rf_wen = 1'b0;
                        ctl.hi_wen = 1'b1;
                        ctl.lo_wen = 1'b1;
                        ctl.alu_op = (funct == mips_isa_pkg::F_MULT) ?
                                     pipe_pkg::ALU_MULT : pipe_pkg::ALU_MULTU;
                    end
                    mips_isa_pkg::F_ADDU: ctl.alu_op = pipe_pkg::ALU_ADD;
                    mips_isa_pkg::F_SUBU: ctl.alu_op = pipe_pkg::ALU_SUB;
                    mips_isa_pkg::F_AND:  ctl.alu_op = pipe_pkg::ALU_AND;
                    mips_isa_pkg::F_OR:   ctl.alu_op = pipe_pkg::ALU_OR;
                    mips_isa_pkg::F_XOR:  ctl.alu_op = pipe_pkg::ALU_XOR;
                    mips_isa_pkg::F_NOR:  ctl.alu_op = pipe_pkg::ALU_NOR;
                    mips_isa_pkg::F_SLT:  ctl.alu_op = pipe_pkg::ALU_SLT;
                    mips_isa_pkg::F_SLTU: ctl.alu_op = pipe_pkg::ALU_SLTU;
                    default: known = 1'b0;
                endcase
            end
            // immediate forms write rt
            mips_isa_pkg::OP_ADDIU: ctl.src2_sel = pipe_pkg::SRC2_SIMM;
            mips_isa_pkg::OP_SLTI: begin
                ctl.alu_op = pipe_pkg::ALU_SLT;
                ctl.src2_sel = pipe_pkg::SRC2_SIMM;
            end
            mips_isa_pkg::OP_ANDI: begin
                ctl.alu_op = pipe_pkg::ALU_AND;
                ctl.src2_sel = pipe_pkg::SRC2_ZIMM;
            end
            mips_isa_pkg::OP_ORI: begin
                ctl.alu_op = pipe_pkg::ALU_OR;
                ctl.src2_sel = pipe_pkg::SRC2_ZIMM;
            end
            mips_isa_pkg::OP_XORI: begin
                ctl.alu_op = pipe_pkg::ALU_XOR;
                ctl.src2_sel = pipe_pkg::SRC2_ZIMM;
            end
            mips_isa_pkg::OP_LUI: begin
                ctl.alu_op = pipe_pkg::ALU_PASSB;
                ctl.src2_sel = pipe_pkg::SRC2_UIMM;
            end
            default: known = 1'b0;
        endcase
        // unknown encodings become bubbles
        if (!known) begin
            ctl = '0;
        end
    end

    always_comb begin
        ex_next.valid = dec_valid && known;
        ex_next.ctl = ctl;
        ex_next.rs = rs_addr;
        ex_next.rt = rt_addr;
        ex_next.rs_data = rs_data;
        ex_next.rt_data = rt_data;
        ex_next.imm = dec_inst[mips_isa_pkg::IMM_LSB +: 16];
        ex_next.shamt = dec_inst[mips_isa_pkg::SHAMT_LSB +: 5];
    end

    // execute slot
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_stage.valid <= 1'b0;
            ex_stage.ctl <= '0;
        end else begin
            ex_stage <= ex_next;
        end
    end

    // a GPR write and a HI write never come from one instruction
    ex_no_dual_write: assert property (@(posedge clk) disable iff (reset)
        ex_stage.valid |-> !(ex_stage.ctl.hi_wen && ex_stage.ctl.rf_wen));

endmodule

// File: src/hilo_reg.sv
module hilo_reg (
    input  logic                clk,
    input  logic                reset,
    input  pipe_pkg::retire_t   retire,
    output mips_isa_pkg::word_t hi,
    output mips_isa_pkg::word_t lo
);

    mips_isa_pkg::word_t hi_q;
    mips_isa_pkg::word_t lo_q;
    logic                hi_wen;
    logic                lo_wen;

    assign hi_wen = retire.valid && retire.hi_wen;
    assign lo_wen = retire.valid && retire.lo_wen;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (hi_wen) begin
                hi_q <= retire.hi_data;
            end
            if (lo_wen) begin
                lo_q <= retire.lo_data;
            end
        end
    end

    // pending write shows through, so mfhi right after mult sees the product
    assign hi = hi_wen ? retire.hi_data : hi_q;
    assign lo = lo_wen ? retire.lo_data : lo_q;

endmodule

// File: src/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;

    // low bit of each instruction field
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_LSB  = 6;
    localparam int FUNCT_LSB  = 0;
    localparam int IMM_LSB    = 0;

    localparam int       REG_COUNT = 32;
    localparam reg_idx_t ZERO_REG  = 5'd0;

    ////////////////////
    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;

    ////////////////////
    // SPECIAL function codes
    localparam funct_t F_SLL   = 6'h00;
    localparam funct_t F_SRL   = 6'h02;
    localparam funct_t F_SRA   = 6'h03;
    localparam funct_t F_MFHI  = 6'h10;
    localparam funct_t F_MTHI  = 6'h11;
    localparam funct_t F_MFLO  = 6'h12;
    localparam funct_t F_MTLO  = 6'h13;
    localparam funct_t F_MULT  = 6'h18;
    localparam funct_t F_MULTU = 6'h19;
    localparam funct_t F_ADDU  = 6'h21;
    localparam funct_t F_SUBU  = 6'h23;
    localparam funct_t F_AND   = 6'h24;
    localparam funct_t F_OR    = 6'h25;
    localparam funct_t F_XOR   = 6'h26;
    localparam funct_t F_NOR   = 6'h27;
    localparam funct_t F_SLT   = 6'h2a;
    localparam funct_t F_SLTU  = 6'h2b;

endpackage

// File: src/operand_bypass.sv
module operand_bypass (
    input  mips_isa_pkg::reg_idx_t src_addr,
    input  mips_isa_pkg::word_t    stale_data,
    input  pipe_pkg::retire_t      retire,
    output mips_isa_pkg::word_t    data
);

    logic hit;

    // r0 is never forwarded, it always reads zero
    assign hit = retire.valid && retire.rf_wen
              && (retire.waddr == src_addr)
              && (src_addr != mips_isa_pkg::ZERO_REG);

    assign data = hit ? retire.result : stale_data;

endmodule

// File: src/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASSB,
        ALU_MULT,
        ALU_MULTU
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_SIMM,
        SRC2_ZIMM,
        SRC2_UIMM
    } src2_sel_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_HI,
        RES_LO
    } result_sel_e;

    typedef struct packed {
        alu_op_e                alu_op;
        src2_sel_e              src2_sel;
        result_sel_e            result_sel;
        logic                   shift_by_shamt;
        logic                   rf_wen;
        mips_isa_pkg::reg_idx_t waddr;
        logic                   hi_wen;
        logic                   lo_wen;
        logic                   hilo_from_rs;
    } ctl_t;

    typedef struct packed {
        logic                   valid;
        ctl_t                   ctl;
        mips_isa_pkg::reg_idx_t rs;
        mips_isa_pkg::reg_idx_t rt;
        mips_isa_pkg::word_t    rs_data;
        mips_isa_pkg::word_t    rt_data;
        mips_isa_pkg::imm_t     imm;
        mips_isa_pkg::shamt_t   shamt;
    } ex_stage_t;

    typedef struct packed {
        logic                   valid;
        logic                   rf_wen;
        mips_isa_pkg::reg_idx_t waddr;
        mips_isa_pkg::word_t    result;
        logic                   hi_wen;
        logic                   lo_wen;
        mips_isa_pkg::word_t    hi_data;
        mips_isa_pkg::word_t    lo_data;
    } retire_t;

endpackage

// File: src/reg_file.sv
module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  mips_isa_pkg::reg_idx_t rs_addr,
    input  mips_isa_pkg::reg_idx_t rt_addr,
    output mips_isa_pkg::word_t    rs_data,
    output mips_isa_pkg::word_t    rt_data,
    input  pipe_pkg::retire_t      retire
);

    mips_isa_pkg::word_t regs [mips_isa_pkg::REG_COUNT];
    logic                wen;

    assign wen = retire.valid && retire.rf_wen && (retire.waddr != mips_isa_pkg::ZERO_REG);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mips_isa_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[retire.waddr] <= retire.result;
        end
    end

    // write-first read so the retiring value wins over storage
    assign rs_data = (wen && retire.waddr == rs_addr) ? retire.result : regs[rs_addr];
    assign rt_data = (wen && retire.waddr == rt_addr) ? retire.result : regs[rt_addr];

    r0_stays_zero: assert property (@(posedge clk) disable iff (reset)
        regs[mips_isa_pkg::ZERO_REG] == '0);

endmodule

// File: src/retire_stage.sv
module retire_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::ex_stage_t    ex_stage,
    input  mips_isa_pkg::word_t    rs_val,
    input  mips_isa_pkg::word_t    alu_result,
    input  mips_isa_pkg::word_t    prod_hi,
    input  mips_isa_pkg::word_t    prod_lo,
    input  mips_isa_pkg::word_t    hi,
    input  mips_isa_pkg::word_t    lo,
    output pipe_pkg::retire_t      retire,
    output logic                   trace_valid,
    output mips_isa_pkg::reg_idx_t trace_wnum,
    output mips_isa_pkg::word_t    trace_wdata
);

    pipe_pkg::retire_t retire_next;

    always_comb begin
        retire_next.valid = ex_stage.valid;
        retire_next.rf_wen = ex_stage.valid && ex_stage.ctl.rf_wen;
        retire_next.waddr = ex_stage.ctl.waddr;
        case (ex_stage.ctl.result_sel)
            pipe_pkg::RES_HI: retire_next.result = hi;
            pipe_pkg::RES_LO: retire_next.result = lo;
            default:          retire_next.result = alu_result;
        endcase
        retire_next.hi_wen = ex_stage.valid && ex_stage.ctl.hi_wen;
        retire_next.lo_wen = ex_stage.valid && ex_stage.ctl.lo_wen;
        // mthi and mtlo take rs, mult takes the product
        retire_next.hi_data = ex_stage.ctl.hilo_from_rs ? rs_val : prod_hi;
        retire_next.lo_data = ex_stage.ctl.hilo_from_rs ? rs_val : prod_lo;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
            retire.rf_wen <= 1'b0;
            retire.hi_wen <= 1'b0;
            retire.lo_wen <= 1'b0;
        end else begin
            retire <= retire_next;
        end
    end

    ////////////////////
    // write-back trace
    always_ff @(posedge clk) begin
        if (reset) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= retire.valid && retire.rf_wen
                        && (retire.waddr != mips_isa_pkg::ZERO_REG);
        end
        trace_wnum <= retire.waddr;
        trace_wdata <= retire.result;
    end

    trace_nonzero_dest: assert property (@(posedge clk) disable iff (reset)
        trace_valid |-> trace_wnum != mips_isa_pkg::ZERO_REG);

endmodule
